//--- bench/adpcm_checker.sv
// Protocol assertions on the host handshake and the frame pulse, bound into the top level
`timescale 1ns/1ps

module adpcm_checker (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 req,
    input logic                 ack,
    input logic                 frame_valid,
    input adpcm_pkg::host_cmd_t cmd
);

    // Failure tallies for the end-of-run summary
    int ack_fails = 0;
    int pulse_fails = 0;
    int cmd_fails = 0;

    // Ack only ever answers a request
    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> $past(req))
    else begin
        ack_fails++;
        $error("ack rose without a pending req");
    end

    // Output frame strobe is a single clock
    valid_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        frame_valid |=> !frame_valid)
    else begin
        pulse_fails++;
        $error("frame_valid held longer than one clock");
    end

    // Host bus frozen while a write is outstanding
    cmd_held: assert property (@(posedge clk) disable iff (!rst_n)
        (req && !ack) |=> $stable(cmd))
    else begin
        cmd_fails++;
        $error("cmd changed while req was waiting for ack");
    end

endmodule

//--- bench/adpcm_clock.sv
// Testbench clock source, a free-running 100 ns clock for the ADPCM back end testbench
`timescale 1ns/1ps

module adpcm_clock (
    output logic clk
);

    // Half of the 100 ns period
    initial clk = 1'b0;
    always #50 clk = ~clk;

endmodule

//--- bench/adpcm_tb.sv
// Testbench for the ADPCM back end that checks random levels and samples against a gain and mix model
`timescale 1ns/1ps

module adpcm_tb;

    localparam int NUM_CH = adpcm_pkg::NUM_CH;
    // Clocks per output sample period
    localparam int PERIOD_CLKS = adpcm_pkg::CEN_DIV * NUM_CH * adpcm_pkg::PASSES_PER_PERIOD;
    localparam int PERIODS_USED = 28;
    localparam int TIMEOUT_NS = (PERIODS_USED * PERIOD_CLKS + 1000) * 100;

    logic                  clk;
    logic                  rst_n;
    logic                  req;
    logic                  ack;
    logic                  frame_valid;
    adpcm_pkg::host_cmd_t  cmd;
    adpcm_pkg::mix_frame_t frame;

    // Model state per channel and the total level
    int         model_val [NUM_CH];
    logic [7:0] model_lvl [NUM_CH];
    logic [5:0] model_atl;
    int         errors;
    int         checks;

    adpcm_clock u_clock (.clk(clk));

    adpcm_top u_adpcm_top (
        .clk(clk), .rst_n(rst_n), .req(req), .cmd(cmd), .ack(ack),
        .frame(frame), .frame_valid(frame_valid)
    );

    bind adpcm_top adpcm_checker u_checker (
        .clk(clk), .rst_n(rst_n), .req(req), .ack(ack),
        .frame_valid(frame_valid), .cmd(cmd)
    );

    // Fraction of 512 for the low three attenuation bits
    function automatic int fraction(input int idx);
        case (idx)
            0: return 512;
            1: return 470;
            2: return 431;
            3: return 395;
            4: return 362;
            5: return 332;
            6: return 305;
            default: return 280;
        endcase
    endfunction

    // Inverted channel plus inverted total gives fraction and shift
    function automatic int attenuate(input int sample, input logic [5:0] att,
                                     input logic [5:0] tl);
        int total;
        int shift;
        int scaled;
        total = (63 - int'(att)) + (63 - int'(tl));
        shift = total / 8;
        if (shift >= 8) begin
            return 0;
        end
        scaled = (sample * fraction(total % 8)) >>> 9;
        return scaled >>> shift;
    endfunction

    function automatic int saturate(input int v);
        if (v > 32767) begin
            return 32767;
        end else if (v < -32768) begin
            return -32768;
        end
        return v;
    endfunction

    // Side 1 is left on level bit 7 and side 0 right on bit 6
    function automatic int mix_side(input int side);
        int acc;
        acc = 0;
        for (int c = 0; c < NUM_CH; c++) begin
            if (model_lvl[c][6 + side]) begin
                acc += model_val[c];
            end
        end
        return saturate(acc);
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        checks++;
        if (expected != actual) begin
            errors++;
            $display("Error: %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_frame(input string name);
        check_value({name, "_left"}, mix_side(1), int'($signed(frame.left)));
        check_value({name, "_right"}, mix_side(0), int'($signed(frame.right)));
    endtask

    // Four-phase write that starts and ends on a falling edge
    task automatic host_write(input adpcm_pkg::host_op_e op, input int ch,
                              input logic [15:0] data, output int waited);
        cmd.op = op;
        cmd.ch = 3'(ch);
        cmd.data = data;
        req = 1'b1;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!ack);
        req = 1'b0;
        while (ack) begin
            @(negedge clk);
        end
    endtask

    task automatic set_total(input logic [5:0] tl);
        int waited;
        host_write(adpcm_pkg::OP_TOTAL_LEVEL, 0, {10'd0, tl}, waited);
        model_atl = tl;
    endtask

    task automatic set_level(input int ch, input logic [1:0] lr, input logic [5:0] att);
        int waited;
        host_write(adpcm_pkg::OP_CHAN_LEVEL, ch, {8'd0, lr, att}, waited);
        model_lvl[ch] = {lr, att};
    endtask

    task automatic write_sample(input int ch, input logic [15:0] value, output int waited);
        host_write(adpcm_pkg::OP_SAMPLE, ch, value, waited);
        model_val[ch] = attenuate(int'($signed(value)), model_lvl[ch][5:0], model_atl);
    endtask

    // Next frame strobe as seen at a falling edge
    task automatic wait_frame();
        @(negedge clk);
        while (!frame_valid) begin
            @(negedge clk);
        end
    endtask

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the DUT stopped answering the host or stopped producing frames");
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        int          chan_t;
        int          waited;
        int          wait_b;
        int          asserts;
        logic        neg;
        logic [15:0] smp;
        errors = 0;
        checks = 0;
        rst_n = 1'b0;
        req = 1'b0;
        cmd = '0;
        model_atl = '0;
        for (int c = 0; c < NUM_CH; c++) begin
            model_val[c] = 0;
            model_lvl[c] = '0;
        end
        void'($urandom(81458));
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Silent after reset
        repeat (3) begin
            wait_frame();
            check_value("reset_left", 0, int'($signed(frame.left)));
            check_value("reset_right", 0, int'($signed(frame.right)));
        end

        // One channel on both sides with no total attenuation
        chan_t = int'($urandom % NUM_CH);
        set_total(6'd63);
        set_level(chan_t, 2'b11, 6'($urandom));
        wait_frame();
        write_sample(chan_t, 16'($urandom), waited);
        // Injected at the next period start and final by its last frame
        wait_frame();
        check_frame("single_channel");

        // Full attenuation everywhere mutes the channel
        set_total(6'd0);
        set_level(chan_t, 2'b11, 6'd0);
        wait_frame();
        write_sample(chan_t, 16'($urandom), waited);
        wait_frame();
        check_value("total_mute_left", 0, int'($signed(frame.left)));
        check_value("total_mute_right", 0, int'($signed(frame.right)));

        // Six full-scale samples of the same sign
        set_total(6'd63);
        for (int c = 0; c < NUM_CH; c++) begin
            set_level(c, 2'b11, 6'd63);
        end
        wait_frame();
        neg = 1'($urandom);
        for (int c = 0; c < NUM_CH; c++) begin
            write_sample(c, neg ? 16'h8000 : 16'h7fff, waited);
        end
        wait_frame();
        check_frame("saturation");
        check_value("saturation_clamp", neg ? -32768 : 32767, int'($signed(frame.left)));

        // Random routing, levels and samples
        set_total(6'(56 + $urandom % 8));
        for (int c = 0; c < NUM_CH; c++) begin
            set_level(c, 2'($urandom), 6'(32 + $urandom % 32));
        end
        wait_frame();
        for (int c = 0; c < NUM_CH; c++) begin
            write_sample(c, 16'($urandom), waited);
        end
        wait_frame();
        check_frame("routing");

        // Two samples on channel 5 in one period where the second one blocks
        set_level(5, 2'b11, 6'd63);
        wait_frame();
        write_sample(5, 16'($urandom), waited);
        check_value("hold_first_ack_wait", 1, waited);
        smp = 16'($urandom);
        host_write(adpcm_pkg::OP_SAMPLE, 5, smp, wait_b);
        check_value("hold_second_ack_late", 1, int'(wait_b > 2));
        wait_frame();
        check_frame("hold_first");
        model_val[5] = attenuate(int'($signed(smp)), model_lvl[5][5:0], model_atl);
        wait_frame();
        check_frame("hold_second");
        wait_frame();
        check_frame("hold_keep");

        asserts = u_adpcm_top.u_checker.ack_fails + u_adpcm_top.u_checker.pulse_fails
                + u_adpcm_top.u_checker.cmd_fails;
        if (asserts != 0) begin
            $display("Protocol assertions failed %0d times", asserts);
            errors += asserts;
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- hdl/adpcm_gain.sv
// Gain pipeline: six-slot level and sample rings that attenuate each channel by level and total level
`timescale 1ns/1ps

module adpcm_gain (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         cen,
    input  logic                         match,
    input  logic [adpcm_pkg::SLOT_W-1:0] cur_slot,
    input  logic [5:0]                   atl,
    input  adpcm_pkg::chan_upd_t         chan_upd,
    output logic                         upd_taken,
    output logic [1:0]                   lr,
    input  logic signed [15:0]           pcm_in,
    output logic signed [15:0]           pcm_att
);

    // Stage k holds the channel cur_slot - (k - 1)
    logic [7:0]         lvl_r [1:6];
    logic [6:0]         db5;
    logic [9:0]         lin_tab;
    logic [9:0]         lin6;
    logic [9:0]         lin1;
    logic [9:0]         lin2;
    logic [3:0]         sh6;
    logic [3:0]         sh1;
    logic signed [15:0] pcm_r [1:6];
    logic [3:0]         cnt_r [1:6];
    logic               match2;
    logic signed [15:0] lin2_s;
    logic signed [31:0] prod;

    // Update enters when its channel sits in stage I
    assign upd_taken = cen && chan_upd.valid && (chan_upd.ch == cur_slot);

    // Outputs for the slot that is closing
    assign lr = lvl_r[1][7:6];
    assign pcm_att = pcm_r[1];

    // Fraction of 512, steps of about 0.75 dB
    always_comb begin
        case (db5[2:0])
            3'd0: lin_tab = 10'd512;
            3'd1: lin_tab = 10'd470;
            3'd2: lin_tab = 10'd431;
            3'd3: lin_tab = 10'd395;
            3'd4: lin_tab = 10'd362;
            3'd5: lin_tab = 10'd332;
            3'd6: lin_tab = 10'd305;
            default: lin_tab = 10'd280;
        endcase
    end

    // Fraction never exceeds 512, product fits in 25 bits
    assign lin2_s = {6'd0, lin2};
    assign prod = pcm_r[2] * lin2_s;

    // Level ring, level to fraction and shift
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 1; k <= 6; k++) begin
                lvl_r[k] <= '0;
            end
            db5  <= '0;
            lin6 <= '0;
            sh6  <= '0;
            lin1 <= '0;
            sh1  <= '0;
        end else if (cen) begin
            // I, pending update replaces the circulating level
            lvl_r[2] <= upd_taken ? chan_upd.level : lvl_r[1];
            // II to V plain transport
            for (int k = 3; k <= 6; k++) begin
                lvl_r[k] <= lvl_r[k-1];
            end
            // IV, inverted attenuations summed
            db5 <= {1'b0, ~lvl_r[4][5:0]} + {1'b0, ~atl};
            // V, table lookup
            lin6 <= lin_tab;
            sh6  <= db5[6:3];
            // VI, shift of 8 or more mutes
            lin1     <= sh6[3] ? 10'd0 : lin6;
            sh1      <= sh6;
            lvl_r[1] <= lvl_r[6];
        end
    end

    // Sample ring, shift spread over passes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 1; k <= 6; k++) begin
                pcm_r[k] <= '0;
                cnt_r[k] <= '0;
            end
            lin2   <= '0;
            match2 <= 1'b0;
        end else if (cen) begin
            // I, injection with fresh shift count
            pcm_r[2] <= match ? pcm_in : pcm_r[1];
            cnt_r[2] <= match ? sh1 : cnt_r[1];
            lin2     <= lin1;
            match2   <= match;
            // II, fraction applied on the injecting pass only
            pcm_r[3] <= match2 ? prod[24:9] : pcm_r[2];
            cnt_r[3] <= cnt_r[2];
            // III to V, one arithmetic place each while count remains
            for (int k = 3; k <= 5; k++) begin
                if (cnt_r[k] != '0) begin
                    pcm_r[k+1] <= pcm_r[k] >>> 1;
                    cnt_r[k+1] <= cnt_r[k] - 4'd1;
                end else begin
                    pcm_r[k+1] <= pcm_r[k];
                    cnt_r[k+1] <= cnt_r[k];
                end
            end
            // VI, loop back and present
            pcm_r[1] <= pcm_r[6];
            cnt_r[1] <= cnt_r[6];
        end
    end

endmodule

//--- hdl/adpcm_host_port.sv
// Host write port: four-phase req/ack decode of level and sample writes toward the pipeline
`timescale 1ns/1ps

module adpcm_host_port (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         req,
    input  adpcm_pkg::host_cmd_t         cmd,
    output logic                         ack,
    output logic [5:0]                   atl,
    output adpcm_pkg::chan_upd_t         chan_upd,
    input  logic                         upd_taken,
    output logic                         smp_wr,
    output logic [adpcm_pkg::SLOT_W-1:0] smp_ch,
    output logic [15:0]                  smp_data,
    input  logic                         smp_full
);

    // Handshake FSM
    typedef enum logic [1:0] {
        IDLE,
        WAIT,
        ACK
    } state_e;

    state_e               state;
    adpcm_pkg::chan_upd_t upd_r;

    // Ack held from acceptance until req drops
    assign ack = (state == ACK);
    assign chan_upd = upd_r;

    // Samples go straight from the bus to the feed
    assign smp_ch = cmd.ch;
    assign smp_data = cmd.data;

    // Sample write as soon as the channel entry is free
    assign smp_wr = req && (state != ACK) && (cmd.op == adpcm_pkg::OP_SAMPLE) && !smp_full;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            atl   <= '0;
            upd_r <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (req) begin
                        case (cmd.op)
                            adpcm_pkg::OP_TOTAL_LEVEL: begin
                                // Takes effect at once
                                atl   <= cmd.data[5:0];
                                state <= ACK;
                            end
                            adpcm_pkg::OP_CHAN_LEVEL: begin
                                upd_r.ch    <= cmd.ch;
                                upd_r.level <= cmd.data[7:0];
                                // Unknown channel never comes round, ack directly
                                if (cmd.ch <= adpcm_pkg::LAST_SLOT) begin
                                    upd_r.valid <= 1'b1;
                                    state       <= WAIT;
                                end else begin
                                    state <= ACK;
                                end
                            end
                            adpcm_pkg::OP_SAMPLE: begin
                                // Occupied entry frees at next period start
                                if (smp_full) begin
                                    state <= WAIT;
                                end else begin
                                    state <= ACK;
                                end
                            end
                            default: state <= ACK;
                        endcase
                    end
                end
                WAIT: begin
                    // Level loaded by the gain ring
                    if (upd_taken) begin
                        upd_r.valid <= 1'b0;
                        state       <= ACK;
                    end else if (smp_wr) begin
                        state <= ACK;
                    end
                end
                ACK: begin
                    if (!req) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

//--- hdl/adpcm_mixer.sv
// Mixer: sums attenuated slots of the closing frame into saturated left and right output frames
`timescale 1ns/1ps

module adpcm_mixer (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         cen,
    input  logic                         last_frame,
    input  logic [adpcm_pkg::SLOT_W-1:0] cur_slot,
    input  logic [1:0]                   lr,
    input  logic signed [15:0]           pcm_att,
    output adpcm_pkg::mix_frame_t        frame,
    output logic                         frame_valid
);

    logic signed [adpcm_pkg::SUM_W-1:0] pcm_ext;
    logic signed [adpcm_pkg::SUM_W-1:0] acc_l;
    logic signed [adpcm_pkg::SUM_W-1:0] acc_r;
    logic signed [adpcm_pkg::SUM_W-1:0] sum_l;
    logic signed [adpcm_pkg::SUM_W-1:0] sum_r;
    logic                               take;

    // Clamp to the 16-bit sample range
    function automatic logic signed [15:0] sat16(input logic signed [adpcm_pkg::SUM_W-1:0] v);
        if (v > 32767) begin
            return 16'sh7fff;
        end else if (v < -32768) begin
            return 16'sh8000;
        end
        return v[15:0];
    endfunction

    assign pcm_ext = {{(adpcm_pkg::SUM_W - 16){pcm_att[15]}}, pcm_att};
    // last_frame only ever comes with an enable
    assign take = cen && last_frame;

    // Slot 0 restarts the sums, lr[1] routes left and lr[0] right
    always_comb begin
        sum_l = (cur_slot == '0) ? '0 : acc_l;
        sum_r = (cur_slot == '0) ? '0 : acc_r;
        if (lr[1]) begin
            sum_l = sum_l + pcm_ext;
        end
        if (lr[0]) begin
            sum_r = sum_r + pcm_ext;
        end
    end

    // Running sums
    always_ff @(posedge clk) begin
        if (take) begin
            acc_l <= sum_l;
            acc_r <= sum_r;
        end
    end

    // Frame publish on the last slot, one-clock valid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame       <= '0;
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= 1'b0;
            if (take && (cur_slot == adpcm_pkg::LAST_SLOT)) begin
                frame.left  <= sat16(sum_l);
                frame.right <= sat16(sum_r);
                frame_valid <= 1'b1;
            end
        end
    end

endmodule

//--- hdl/adpcm_pkg.sv
// Shared constants, host opcodes and bus structs of the ADPCM playback back end, used by scoped name
package adpcm_pkg;

    // Channel count, one pipeline slot per channel
    localparam int NUM_CH = 6;
    // Clocks per pipeline enable
    localparam int CEN_DIV = 6;
    // Ring frames per output sample period
    localparam int PASSES_PER_PERIOD = 4;

    // Counter widths
    localparam int SLOT_W = 3;
    localparam int DIV_W = $clog2(CEN_DIV);
    localparam int FRAME_W = $clog2(PASSES_PER_PERIOD);

    // Mixer accumulator width, room for six full-scale samples
    localparam int SUM_W = 20;

    // Terminal counts
    localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(NUM_CH - 1);
    localparam logic [DIV_W-1:0] LAST_DIV = DIV_W'(CEN_DIV - 1);
    localparam logic [FRAME_W-1:0] LAST_FRAME = FRAME_W'(PASSES_PER_PERIOD - 1);

    // Host write opcodes
    typedef enum logic [1:0] {
        OP_TOTAL_LEVEL,
        OP_CHAN_LEVEL,
        OP_SAMPLE
    } host_op_e;

    // Host write bus
    // Total level in data[5:0]
    // Channel level: data[7:6] left/right, data[5:0] attenuation
    typedef struct packed {
        host_op_e          op;
        logic [SLOT_W-1:0] ch;
        logic [15:0]       data;
    } host_cmd_t;

    // Pending channel level update, waits for its slot in the gain ring
    typedef struct packed {
        logic              valid;
        logic [SLOT_W-1:0] ch;
        logic [7:0]        level;
    } chan_upd_t;

    // Mixed stereo output frame
    typedef struct packed {
        logic signed [15:0] left;
        logic signed [15:0] right;
    } mix_frame_t;

endpackage

//--- hdl/adpcm_sample_feed.sv
// Sample feed: holds one decoded sample per channel and injects it into the gain ring each period
`timescale 1ns/1ps

module adpcm_sample_feed (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         cen,
    input  logic                         period_start,
    input  logic [adpcm_pkg::SLOT_W-1:0] cur_slot,
    input  logic                         smp_wr,
    input  logic [adpcm_pkg::SLOT_W-1:0] smp_ch,
    input  logic [15:0]                  smp_data,
    output logic                         smp_full,
    output logic                         match,
    output logic signed [15:0]           pcm_in
);

    logic signed [15:0]              buf_r [adpcm_pkg::NUM_CH];
    logic [adpcm_pkg::NUM_CH-1:0]    vld;
    // Rest of frame 0 after the period_start enable
    logic                            win;
    logic                            active;
    logic                            ch_ok;

    assign ch_ok = (smp_ch <= adpcm_pkg::LAST_SLOT);
    assign smp_full = ch_ok && vld[smp_ch];

    // Gain stage I works on the channel of cur_slot, so no slot offset
    assign active = period_start || win;
    assign match = cen && active && vld[cur_slot];
    assign pcm_in = buf_r[cur_slot];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld <= '0;
            win <= 1'b0;
        end else begin
            if (period_start) begin
                win <= 1'b1;
            end else if (cen && (cur_slot == adpcm_pkg::LAST_SLOT)) begin
                win <= 1'b0;
            end
            // Entry consumed on injection
            if (match) begin
                vld[cur_slot] <= 1'b0;
            end
            // Writes only reach empty entries
            if (smp_wr && ch_ok) begin
                vld[smp_ch] <= 1'b1;
            end
        end
    end

    // Sample storage
    always_ff @(posedge clk) begin
        if (smp_wr && ch_ok) begin
            buf_r[smp_ch] <= smp_data;
        end
    end

endmodule

//--- hdl/adpcm_slot_timer.sv
// Slot timer: clock enable, rotating channel slot and sample period markers for all blocks
`timescale 1ns/1ps

module adpcm_slot_timer (
    input  logic                         clk,
    input  logic                         rst_n,
    output logic                         cen,
    output logic                         period_start,
    output logic                         last_frame,
    output logic [adpcm_pkg::SLOT_W-1:0] cur_slot
);

    // Enable divider and frame counter
    logic [adpcm_pkg::DIV_W-1:0]   div_cnt;
    logic [adpcm_pkg::FRAME_W-1:0] frame_cnt;

    // One clock in CEN_DIV
    assign cen = (div_cnt == adpcm_pkg::LAST_DIV);

    // First slot of frame 0 opens a period
    assign period_start = cen && (frame_cnt == '0) && (cur_slot == '0);

    // Every enable of the closing frame
    assign last_frame = cen && (frame_cnt == adpcm_pkg::LAST_FRAME);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt   <= '0;
            cur_slot  <= '0;
            frame_cnt <= '0;
        end else begin
            if (cen) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
            // Slot advances once per enable
            if (cen) begin
                if (cur_slot == adpcm_pkg::LAST_SLOT) begin
                    cur_slot <= '0;
                    // Frame wraps at period end
                    if (frame_cnt == adpcm_pkg::LAST_FRAME) begin
                        frame_cnt <= '0;
                    end else begin
                        frame_cnt <= frame_cnt + 1'b1;
                    end
                end else begin
                    cur_slot <= cur_slot + 1'b1;
                end
            end
        end
    end

endmodule

//--- hdl/adpcm_top.sv
// Top level of the ADPCM playback back end, wires host port, timer, feed, gain ring and mixer
`timescale 1ns/1ps

module adpcm_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req,
    input  adpcm_pkg::host_cmd_t  cmd,
    output logic                  ack,
    output adpcm_pkg::mix_frame_t frame,
    output logic                  frame_valid
);

    // Slot timing
    logic                         cen;
    logic                         period_start;
    logic                         last_frame;
    logic [adpcm_pkg::SLOT_W-1:0] cur_slot;
    // Host side
    logic [5:0]                   atl;
    adpcm_pkg::chan_upd_t         chan_upd;
    logic                         upd_taken;
    logic                         smp_wr;
    logic [adpcm_pkg::SLOT_W-1:0] smp_ch;
    logic [15:0]                  smp_data;
    logic                         smp_full;
    // Ring data
    logic                         match;
    logic signed [15:0]           pcm_in;
    logic [1:0]                   lr;
    logic signed [15:0]           pcm_att;

    adpcm_slot_timer u_timer (
        .clk(clk), .rst_n(rst_n), .cen(cen), .period_start(period_start),
        .last_frame(last_frame), .cur_slot(cur_slot)
    );

    adpcm_host_port u_host (
        .clk(clk), .rst_n(rst_n), .req(req), .cmd(cmd), .ack(ack), .atl(atl),
        .chan_upd(chan_upd), .upd_taken(upd_taken), .smp_wr(smp_wr),
        .smp_ch(smp_ch), .smp_data(smp_data), .smp_full(smp_full)
    );

    adpcm_sample_feed u_feed (
        .clk(clk), .rst_n(rst_n), .cen(cen), .period_start(period_start),
        .cur_slot(cur_slot), .smp_wr(smp_wr), .smp_ch(smp_ch), .smp_data(smp_data),
        .smp_full(smp_full), .match(match), .pcm_in(pcm_in)
    );

    adpcm_gain u_gain (
        .clk(clk), .rst_n(rst_n), .cen(cen), .match(match), .cur_slot(cur_slot),
        .atl(atl), .chan_upd(chan_upd), .upd_taken(upd_taken), .lr(lr),
        .pcm_in(pcm_in), .pcm_att(pcm_att)
    );

    adpcm_mixer u_mixer (
        .clk(clk), .rst_n(rst_n), .cen(cen), .last_frame(last_frame),
        .cur_slot(cur_slot), .lr(lr), .pcm_att(pcm_att), .frame(frame),
        .frame_valid(frame_valid)
    );

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build and run the ADPCM back end testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal -f sources.f --top-module adpcm_tb \
    -Mdir obj_dir -o adpcm_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/adpcm_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "Simulation PASSED" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0

//--- sources.f
hdl/adpcm_pkg.sv
hdl/adpcm_slot_timer.sv
hdl/adpcm_host_port.sv
hdl/adpcm_sample_feed.sv
hdl/adpcm_gain.sv
hdl/adpcm_mixer.sv
hdl/adpcm_top.sv
bench/adpcm_clock.sv
bench/adpcm_checker.sv
bench/adpcm_tb.sv
